//--- vlog.f
+incdir+hdl
hdl/sci_pkg.sv
hdl/sci_uart_if.sv
hdl/sci_baud_gen.sv
hdl/sci_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart.sv
hdl/dps_sci.sv
test/tb_dps_sci.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -f vlog.f --top-module tb_dps_sci \
	&& ./obj_dir/Vtb_dps_sci 2>&1 | tee "$log" \
	|| { echo "Verilator build or simulation run failed"; exit 1; }

grep -q "ERRORS FOUND" "$log" \
	&& { echo "Simulation reported failures, see $log"; exit 1; }

echo "Simulation passed"
exit 0

//--- test/tb_dps_sci.sv
`default_nettype none
`timescale 1ns/10ps

`include "sci_params.svh"

module tb_dps_sci;

	// One frame at baud select 0
	localparam int FRAME_CYCLES = 10 * `SCI_OVERSAMPLE * `SCI_DIV_UNIT;

	logic iIF_CLOCK;
	logic inRESET;
	logic iREQ_VALID;
	logic iREQ_RW;
	sci_pkg::sci_addr_t iREQ_ADDR;
	logic [31:0] iREQ_DATA;
	logic iIRQ_ACK;
	logic oREQ_BUSY;
	logic oREQ_VALID;
	logic [31:0] oREQ_DATA;
	logic oIRQ_VALID;
	wire serial_line;

	int errors = 0;
	int line_errors = 0;
	int idle_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start = 0;
	integer seed;
	logic line_hold;
	sci_pkg::sci_byte_t expected_q [$];

	// Loopback through the serial line
	dps_sci dut_i (
		.iIF_CLOCK (iIF_CLOCK),
		.inRESET (inRESET),
		.iREQ_VALID (iREQ_VALID),
		.oREQ_BUSY (oREQ_BUSY),
		.iREQ_RW (iREQ_RW),
		.iREQ_ADDR (iREQ_ADDR),
		.iREQ_DATA (iREQ_DATA),
		.oREQ_VALID (oREQ_VALID),
		.oREQ_DATA (oREQ_DATA),
		.oIRQ_VALID (oIRQ_VALID),
		.iIRQ_ACK (iIRQ_ACK),
		.oUART_TXD (serial_line),
		.iUART_RXD (serial_line)
	);

	initial begin
		iIF_CLOCK = 1'b0;
		forever #50 iIF_CLOCK = ~iIF_CLOCK;
	end

	// Line stays idle while the transmitter is held off
	assert property (@(posedge iIF_CLOCK) disable iff (!inRESET) line_hold |-> serial_line)
		else begin
			$display("CHECK FAILED oUART_TXD: got %h expected %h", $sampled(serial_line), 1'b1);
			line_errors++;
		end

	// No stale data on an idle bus
	assert property (@(posedge iIF_CLOCK) disable iff (!inRESET)
		!oREQ_VALID |-> oREQ_DATA == 32'd0)
		else begin
			$display("CHECK FAILED oREQ_DATA: got %h expected %h", $sampled(oREQ_DATA), 32'd0);
			idle_errors++;
		end

	function automatic int error_total();
		return errors + line_errors + idle_errors;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string what);
		$display("Timeout while %s", what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (error_total() != errors_at_start) begin
			tests_failed++;
			$display("%s: failed", name);
		end else begin
			$display("%s: passed", name);
		end
		errors_at_start = error_total();
	endtask

	// Bus write that reports whether the TX FIFO had room
	task automatic write_reg(input sci_pkg::sci_addr_t addr, input logic [31:0] data,
		output logic accepted);
		@(posedge iIF_CLOCK);
		#10;
		iREQ_VALID = 1'b1;
		iREQ_RW = 1'b1;
		iREQ_ADDR = addr;
		iREQ_DATA = data;
		#50;
		accepted = !oREQ_BUSY;
		@(posedge iIF_CLOCK);
		#10;
		iREQ_VALID = 1'b0;
		iREQ_RW = 1'b0;
		iREQ_DATA = 32'd0;
	endtask

	// Combinational response sampled mid cycle
	task automatic read_reg(input sci_pkg::sci_addr_t addr, output logic valid,
		output logic [31:0] data);
		@(posedge iIF_CLOCK);
		#10;
		iREQ_VALID = 1'b1;
		iREQ_RW = 1'b0;
		iREQ_ADDR = addr;
		#50;
		valid = oREQ_VALID;
		data = oREQ_DATA;
		@(posedge iIF_CLOCK);
		#10;
		iREQ_VALID = 1'b0;
	endtask

	task automatic set_config(input logic ten, input logic ren, input sci_pkg::sci_bdr_t bdr,
		input sci_pkg::sci_ire_t ire);
		logic ok;
		write_reg(`SCI_ADDR_CFG, {23'd0, ire, bdr, ren, ten}, ok);
	endtask

	// Retries while the TX FIFO is full
	task automatic send_byte(input sci_pkg::sci_byte_t b);
		logic ok;
		int tries;
		ok = 1'b0;
		tries = 0;
		while (!ok) begin
			if (tries == 4 * FRAME_CYCLES) abort_run("waiting for room in the transmit FIFO");
			write_reg(`SCI_ADDR_TX, {24'd0, b}, ok);
			tries++;
		end
		expected_q.push_back(b);
	endtask

	task automatic receive_byte(input int limit);
		logic valid;
		logic [31:0] data;
		sci_pkg::sci_byte_t exp;
		int polls;
		valid = 1'b0;
		polls = 0;
		while (!valid) begin
			if (polls == limit) abort_run("waiting for a received byte");
			read_reg(`SCI_ADDR_RX, valid, data);
			polls++;
		end
		if (expected_q.size() == 0) begin
			$display("Received a byte that was never sent");
			errors++;
		end else begin
			exp = expected_q.pop_front();
			check_equal("oREQ_DATA", data, {1'b1, 23'd0, exp});
		end
	endtask

	task automatic wait_irq(input logic level, input int limit);
		int n;
		n = 0;
		while (oIRQ_VALID !== level) begin
			if (n == limit) abort_run("waiting for oIRQ_VALID to change");
			@(posedge iIF_CLOCK);
			#10;
			n++;
		end
	endtask

	task automatic ack_irq();
		@(posedge iIF_CLOCK);
		#10;
		iIRQ_ACK = 1'b1;
		@(posedge iIF_CLOCK);
		#10;
		iIRQ_ACK = 1'b0;
	endtask

	initial begin
		logic valid;
		logic [31:0] data;
		logic [8:0] cfg;
		logic ok;
		int i;
		seed = 46;
		line_hold = 1'b0;
		iREQ_VALID = 1'b0;
		iREQ_RW = 1'b0;
		iREQ_ADDR = '0;
		iREQ_DATA = 32'd0;
		iIRQ_ACK = 1'b0;
		inRESET = 1'b0;
		repeat (3) @(posedge iIF_CLOCK);
		#10;
		inRESET = 1'b1;

		check_equal("oUART_TXD", 32'(serial_line), 32'd1);
		check_equal("oIRQ_VALID", 32'(oIRQ_VALID), 32'd0);
		check_equal("oREQ_BUSY", 32'(oREQ_BUSY), 32'd0);
		read_reg(`SCI_ADDR_RX, valid, data);
		check_equal("oREQ_VALID", 32'(valid), 32'd0);
		check_equal("oREQ_DATA", data, 32'd0);
		read_reg(`SCI_ADDR_CFG, valid, data);
		check_equal("oREQ_VALID", 32'(valid), 32'd1);
		check_equal("oREQ_DATA", data, 32'd0);
		finish_test("reset values");

		cfg = 9'($random(seed));
		write_reg(`SCI_ADDR_CFG, {23'd0, cfg}, ok);
		read_reg(`SCI_ADDR_CFG, valid, data);
		check_equal("oREQ_VALID", 32'(valid), 32'd1);
		check_equal("oREQ_DATA", data, {23'd0, cfg});
		finish_test("config readback");

		set_config(1'b1, 1'b1, 4'd0, 3'd0);
		send_byte(8'($random(seed)));
		receive_byte(2 * FRAME_CYCLES);
		finish_test("single byte loopback");

		// Fill the TX FIFO with the transmitter off
		set_config(1'b0, 1'b1, 4'd3, 3'd0);
		for (i = 0; i < `SCI_FIFO_DEPTH; i++) begin
			send_byte(8'($random(seed)));
		end
		check_equal("oREQ_BUSY", 32'(oREQ_BUSY), 32'd1);
		set_config(1'b1, 1'b1, 4'd3, 3'd0);
		for (i = 0; i < `SCI_FIFO_DEPTH; i++) begin
			receive_byte(4 * FRAME_CYCLES);
		end
		finish_test("burst order and back-pressure");

		set_config(1'b0, 1'b1, 4'd0, 3'd0);
		send_byte(8'($random(seed)));
		line_hold = 1'b1;
		repeat (FRAME_CYCLES) @(posedge iIF_CLOCK);
		#10;
		line_hold = 1'b0;
		set_config(1'b1, 1'b1, 4'd0, 3'd0);
		receive_byte(2 * FRAME_CYCLES);
		finish_test("transmit disabled");

		// Byte received source
		set_config(1'b1, 1'b1, 4'd0, 3'b001);
		send_byte(8'($random(seed)));
		wait_irq(1'b1, 2 * FRAME_CYCLES);
		receive_byte(4);
		ack_irq();
		wait_irq(1'b0, 4);
		// All sources masked
		set_config(1'b1, 1'b1, 4'd0, 3'b000);
		send_byte(8'($random(seed)));
		receive_byte(2 * FRAME_CYCLES);
		check_equal("oIRQ_VALID", 32'(oIRQ_VALID), 32'd0);
		// Overflow source with a ninth byte that gets lost
		set_config(1'b1, 1'b1, 4'd0, 3'b100);
		for (i = 0; i <= `SCI_FIFO_DEPTH; i++) begin
			send_byte(8'($random(seed)));
		end
		wait_irq(1'b1, 12 * FRAME_CYCLES);
		expected_q.delete(expected_q.size() - 1);
		for (i = 0; i < `SCI_FIFO_DEPTH; i++) begin
			receive_byte(4);
		end
		read_reg(`SCI_ADDR_RX, valid, data);
		check_equal("oREQ_VALID", 32'(valid), 32'd0);
		ack_irq();
		wait_irq(1'b0, 4);
		finish_test("interrupts");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
		if (error_total() == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/dps_sci.sv
`default_nettype none
`timescale 1ns/10ps

`include "sci_params.svh"

module dps_sci (
	input wire logic iIF_CLOCK,
	input wire logic inRESET,
	// CPU bus
	input wire logic iREQ_VALID,
	output logic oREQ_BUSY,
	input wire logic iREQ_RW,
	input sci_pkg::sci_addr_t iREQ_ADDR,
	input wire logic [31:0] iREQ_DATA,
	output logic oREQ_VALID,
	output logic [31:0] oREQ_DATA,
	// Interrupt
	output logic oIRQ_VALID,
	input wire logic iIRQ_ACK,
	// Serial line
	output logic oUART_TXD,
	input wire logic iUART_RXD
);

	typedef enum logic {
		irq_idle,
		irq_pend
	} irq_state_t;

	logic cfg_ten;
	logic cfg_ren;
	sci_pkg::sci_bdr_t cfg_bdr;
	sci_pkg::sci_ire_t cfg_ire;

	logic wr_tx;
	logic wr_cfg;
	logic rd_rx;
	logic rd_cfg;
	logic baud_tick;
	logic irq_event;
	irq_state_t irq_state;

	sci_uart_if sci_bus ();

	assign wr_tx = iREQ_VALID && iREQ_RW && (iREQ_ADDR == `SCI_ADDR_TX);
	assign wr_cfg = iREQ_VALID && iREQ_RW && (iREQ_ADDR == `SCI_ADDR_CFG);
	assign rd_rx = iREQ_VALID && !iREQ_RW && (iREQ_ADDR == `SCI_ADDR_RX);
	assign rd_cfg = iREQ_VALID && !iREQ_RW && (iREQ_ADDR == `SCI_ADDR_CFG);

	// Layout: ten[0], ren[1], bdr[5:2], ire[8:6]
	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cfg_ten <= 1'b0;
			cfg_ren <= 1'b0;
			cfg_bdr <= '0;
			cfg_ire <= '0;
		end else if (wr_cfg) begin
			cfg_ten <= iREQ_DATA[0];
			cfg_ren <= iREQ_DATA[1];
			cfg_bdr <= iREQ_DATA[5:2];
			cfg_ire <= iREQ_DATA[8:6];
		end
	end

	// Strobes only fire when the FIFO can take them
	assign sci_bus.tx_en = cfg_ten;
	assign sci_bus.rx_en = cfg_ren;
	assign sci_bus.tx_push = wr_tx && !sci_bus.tx_full;
	assign sci_bus.tx_data = iREQ_DATA[7:0];
	assign sci_bus.rx_pop = rd_rx && !sci_bus.rx_empty;

	sci_baud_gen baud_i (
		.iIF_CLOCK (iIF_CLOCK),
		.inRESET (inRESET),
		.bdr (cfg_bdr),
		.tick (baud_tick)
	);

	uart uart_i (
		.iIF_CLOCK (iIF_CLOCK),
		.inRESET (inRESET),
		.tick (baud_tick),
		.rxd (iUART_RXD),
		.txd (oUART_TXD),
		.bus (sci_bus)
	);

	// Read mux, answered in the same cycle
	assign oREQ_BUSY = sci_bus.tx_full;
	assign oREQ_VALID = sci_bus.rx_pop || rd_cfg;

	always_comb begin
		if (sci_bus.rx_pop) begin
			oREQ_DATA = {1'b1, 23'd0, sci_bus.rx_data};
		end else if (rd_cfg) begin
			oREQ_DATA = {23'd0, cfg_ire, cfg_bdr, cfg_ren, cfg_ten};
		end else begin
			oREQ_DATA = 32'd0;
		end
	end

	// Masked event sources
	assign irq_event = |(cfg_ire & {sci_bus.ev_rx_ovf, sci_bus.ev_tx_idle, sci_bus.ev_rx_byte});

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			irq_state <= irq_idle;
		end else begin
			case (irq_state)
				irq_idle: begin
					if (irq_event) begin
						irq_state <= irq_pend;
					end
				end
				irq_pend: begin
					// A new event in the ack cycle keeps the request up
					if (iIRQ_ACK && !irq_event) begin
						irq_state <= irq_idle;
					end
				end
				default: irq_state <= irq_idle;
			endcase
		end
	end

	assign oIRQ_VALID = (irq_state == irq_pend);

endmodule

`default_nettype wire

//--- hdl/uart.sv
`default_nettype none
`timescale 1ns/10ps

module uart (
	input wire logic iIF_CLOCK,
	input wire logic inRESET,
	input wire logic tick,
	input wire logic rxd,
	output logic txd,
	sci_uart_if.uart bus
);

	sci_pkg::sci_byte_t tx_head;
	logic tx_empty;
	logic tx_pop;
	logic tx_done;
	sci_pkg::sci_byte_t rx_byte;
	logic rx_valid;
	logic rx_full;

	// Transmit side
	sci_fifo tx_fifo_i (
		.iIF_CLOCK (iIF_CLOCK),
		.inRESET (inRESET),
		.push (bus.tx_push),
		.wdata (bus.tx_data),
		.pop (tx_pop),
		.rdata (tx_head),
		.full (bus.tx_full),
		.empty (tx_empty),
		.ovf ()
	);

	uart_tx tx_i (
		.iIF_CLOCK (iIF_CLOCK),
		.inRESET (inRESET),
		.tick (tick),
		.en (bus.tx_en),
		.fifo_empty (tx_empty),
		.fifo_data (tx_head),
		.fifo_pop (tx_pop),
		.txd (txd),
		.done (tx_done)
	);

	// Receive side
	uart_rx rx_i (
		.iIF_CLOCK (iIF_CLOCK),
		.inRESET (inRESET),
		.tick (tick),
		.en (bus.rx_en),
		.rxd (rxd),
		.byte_valid (rx_valid),
		.byte_data (rx_byte)
	);

	sci_fifo rx_fifo_i (
		.iIF_CLOCK (iIF_CLOCK),
		.inRESET (inRESET),
		.push (rx_valid),
		.wdata (rx_byte),
		.pop (bus.rx_pop),
		.rdata (bus.rx_data),
		.full (rx_full),
		.empty (bus.rx_empty),
		.ovf (bus.ev_rx_ovf)
	);

	// Only bytes that made it into the FIFO count as received
	assign bus.ev_rx_byte = rx_valid && !rx_full;

	// Frame finished and nothing left to send
	assign bus.ev_tx_idle = tx_done && tx_empty;

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
`default_nettype none
`timescale 1ns/10ps

`include "sci_params.svh"

module uart_rx (
	input wire logic iIF_CLOCK,
	input wire logic inRESET,
	input wire logic tick,
	input wire logic en,
	input wire logic rxd,
	output logic byte_valid,
	output sci_pkg::sci_byte_t byte_data
);

	logic [1:0] sync;
	logic rxd_s;
	sci_pkg::rx_state_t state;
	logic [3:0] tick_cnt;
	logic [2:0] bit_idx;
	logic half_bit;
	logic full_bit;

	// Two flop synchronizer, idles high like the line
	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			sync <= 2'b11;
		end else begin
			sync <= {sync[0], rxd};
		end
	end

	assign rxd_s = sync[1];

	assign half_bit = tick && (tick_cnt == 4'(`SCI_OVERSAMPLE / 2 - 1));
	assign full_bit = tick && (tick_cnt == 4'(`SCI_OVERSAMPLE - 1));

	// Stop bit sampled high, byte goes to the FIFO at this edge
	assign byte_valid = full_bit && (state == sci_pkg::rx_stop) && rxd_s;

	always_ff @(posedge iIF_CLOCK) begin
		if (full_bit && state == sci_pkg::rx_data) begin
			byte_data <= {rxd_s, byte_data[7:1]};
		end
	end

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= sci_pkg::rx_idle;
			tick_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				sci_pkg::rx_idle: begin
					tick_cnt <= '0;
					if (tick && en && !rxd_s) begin
						state <= sci_pkg::rx_start;
					end
				end
				sci_pkg::rx_start: begin
					if (half_bit) begin
						tick_cnt <= '0;
						bit_idx <= '0;
						// A glitch back to high is not a start bit
						state <= rxd_s ? sci_pkg::rx_idle : sci_pkg::rx_data;
					end else if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				sci_pkg::rx_data: begin
					if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
					if (full_bit) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= sci_pkg::rx_stop;
						end
					end
				end
				sci_pkg::rx_stop: begin
					if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
					if (full_bit) begin
						state <= sci_pkg::rx_idle;
					end
				end
				default: state <= sci_pkg::rx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/uart_tx.sv
`default_nettype none
`timescale 1ns/10ps

`include "sci_params.svh"

module uart_tx (
	input wire logic iIF_CLOCK,
	input wire logic inRESET,
	input wire logic tick,
	input wire logic en,
	input wire logic fifo_empty,
	input sci_pkg::sci_byte_t fifo_data,
	output logic fifo_pop,
	output logic txd,
	output logic done
);

	sci_pkg::tx_state_t state;
	logic [3:0] tick_cnt;
	logic [2:0] bit_idx;
	sci_pkg::sci_byte_t shift;
	logic bit_end;

	// Last tick of the current bit
	assign bit_end = tick && (tick_cnt == 4'(`SCI_OVERSAMPLE - 1));

	assign fifo_pop = tick && en && !fifo_empty && (state == sci_pkg::tx_idle);
	assign done = bit_end && (state == sci_pkg::tx_stop);

	always_ff @(posedge iIF_CLOCK) begin
		if (fifo_pop) begin
			shift <= fifo_data;
		end else if (bit_end && state == sci_pkg::tx_data) begin
			shift <= {1'b0, shift[7:1]};
		end
	end

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= sci_pkg::tx_idle;
			tick_cnt <= '0;
			bit_idx <= '0;
			txd <= 1'b1;
		end else begin
			if (tick) begin
				tick_cnt <= (state == sci_pkg::tx_idle) ? 4'd0 : tick_cnt + 1'b1;
			end
			case (state)
				sci_pkg::tx_idle: begin
					if (fifo_pop) begin
						state <= sci_pkg::tx_start;
						txd <= 1'b0;
					end
				end
				sci_pkg::tx_start: begin
					if (bit_end) begin
						state <= sci_pkg::tx_data;
						bit_idx <= '0;
						txd <= shift[0];
					end
				end
				sci_pkg::tx_data: begin
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							state <= sci_pkg::tx_stop;
							txd <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							txd <= shift[1];
						end
					end
				end
				sci_pkg::tx_stop: begin
					if (bit_end) begin
						state <= sci_pkg::tx_idle;
					end
				end
				default: state <= sci_pkg::tx_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/sci_fifo.sv
`default_nettype none
`timescale 1ns/10ps

`include "sci_params.svh"

module sci_fifo (
	input wire logic iIF_CLOCK,
	input wire logic inRESET,
	input wire logic push,
	input sci_pkg::sci_byte_t wdata,
	input wire logic pop,
	output sci_pkg::sci_byte_t rdata,
	output logic full,
	output logic empty,
	output logic ovf
);

	sci_pkg::sci_byte_t mem [`SCI_FIFO_DEPTH];

	logic [`SCI_FIFO_AW-1:0] wr_ptr;
	logic [`SCI_FIFO_AW-1:0] rd_ptr;
	sci_pkg::sci_fifo_cnt_t count;
	logic do_push;
	logic do_pop;

	assign full = (count == sci_pkg::sci_fifo_cnt_t'(`SCI_FIFO_DEPTH));
	assign empty = (count == '0);

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// A push into a full buffer is lost
	assign ovf = push && full;

	always_ff @(posedge iIF_CLOCK) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
	end

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head of queue is visible without a read cycle
	assign rdata = mem[rd_ptr];

endmodule

`default_nettype wire

//--- hdl/sci_baud_gen.sv
`default_nettype none
`timescale 1ns/10ps

`include "sci_params.svh"

module sci_baud_gen (
	input wire logic iIF_CLOCK,
	input wire logic inRESET,
	input sci_pkg::sci_bdr_t bdr,
	output logic tick
);

	// Wide enough for the slowest divider, 16 steps of the unit
	localparam int CW = 7;

	logic [CW-1:0] cnt;
	logic [CW-1:0] reload;

	// Tick period is (bdr + 1) units, counted from reload down to zero
	assign reload = CW'((int'(bdr) + 1) * `SCI_DIV_UNIT - 1);

	always_ff @(posedge iIF_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cnt <= '0;
		end else if (cnt == '0) begin
			cnt <= reload;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign tick = (cnt == '0);

endmodule

`default_nettype wire

//--- hdl/sci_uart_if.sv
`default_nettype none
`timescale 1ns/10ps

interface sci_uart_if;

	// Register block to UART
	logic tx_en;
	logic rx_en;
	logic tx_push;
	sci_pkg::sci_byte_t tx_data;
	logic rx_pop;

	// UART to register block
	logic tx_full;
	logic rx_empty;
	sci_pkg::sci_byte_t rx_data;
	logic ev_rx_byte;
	logic ev_tx_idle;
	logic ev_rx_ovf;

	modport regs (
		output tx_en, rx_en, tx_push, tx_data, rx_pop,
		input tx_full, rx_empty, rx_data, ev_rx_byte, ev_tx_idle, ev_rx_ovf
	);

	modport uart (
		input tx_en, rx_en, tx_push, tx_data, rx_pop,
		output tx_full, rx_empty, rx_data, ev_rx_byte, ev_tx_idle, ev_rx_ovf
	);

endinterface

`default_nettype wire

//--- hdl/sci_pkg.sv
`default_nettype none

`include "sci_params.svh"

package sci_pkg;

	typedef logic [7:0] sci_byte_t;
	typedef logic [1:0] sci_addr_t;
	typedef logic [3:0] sci_bdr_t;

	// Bit 0 byte received, bit 1 transmitter idle, bit 2 receive overflow
	typedef logic [2:0] sci_ire_t;

	// One bit wider than the pointers so that a full FIFO can be counted
	typedef logic [`SCI_FIFO_AW:0] sci_fifo_cnt_t;

	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_t;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

endpackage

`default_nettype wire

//--- hdl/sci_params.svh
`ifndef SCI_PARAMS_SVH
`define SCI_PARAMS_SVH

// FIFO geometry, same for transmit and receive
`define SCI_FIFO_DEPTH 8
`define SCI_FIFO_AW 3

// Ticks per bit on the line
`define SCI_OVERSAMPLE 16

// Clock cycles per tick for each baud select step
`define SCI_DIV_UNIT 4

// Register word addresses
`define SCI_ADDR_TX 2'd0
`define SCI_ADDR_RX 2'd1
`define SCI_ADDR_CFG 2'd2

`endif
